// ==== csr_unit.f ====
hdl/csr_pkg.sv
hdl/csr_addr_decode.sv
hdl/csr_status_irq.sv
hdl/csr_trap_regs.sv
hdl/csr_counters.sv
hdl/csr_custom_regs.sv
hdl/csr_read_mux.sv
hdl/csr_unit_top.sv
testbench/tb_clock_gen.sv
testbench/csr_unit_properties.sv
testbench/csr_unit_tb.sv

// ==== testbench/csr_unit_tb.sv ====
// Directed testbench for the machine-mode CSR unit
// Register read/write, trap and MRET, commit priority, mip sampling
// Counter load, carry and stop, custom register masks and core control
`timescale 1ns/1ps

module csr_unit_tb;
  import csr_pkg::*;

  localparam logic [XLEN-1:0] TB_MTVEC        = 32'h0000_0180;
  localparam logic [XLEN-1:0] MSTATUS_LIVE    = 32'h0000_0088;  // MPIE bit 7, MIE bit 3
  localparam int              EDGE_TIMEOUT_NS = 100;            // 2.5 clock periods
  localparam int              SETTLE_NS       = 5;

  logic               clk;
  logic               rst_n;
  csr_req_t           req;
  cmt_t               cmt;
  irq_in_t            irq;
  logic [XLEN-1:0]    read_csr_dat;
  irq_en_t            irq_en;
  core_ctl_t          core_ctl;
  logic [PC_SIZE-1:0] csr_epc_r;
  logic [XLEN-1:0]    csr_mtvec_r;
  int                 check_cnt;
  int                 err_cnt;
  int                 seed;

  tb_clock_gen u_clk (.clk(clk));

  // Both clock domains share the testbench clock
  csr_unit_top #(.HART_ID(1'b1), .MTVEC_BASE(TB_MTVEC)) UUT (
    .clk(clk), .clk_aon(clk), .rst_n(rst_n), .req(req), .cmt(cmt), .irq(irq),
    .read_csr_dat(read_csr_dat), .irq_en(irq_en), .core_ctl(core_ctl),
    .csr_epc_r(csr_epc_r), .csr_mtvec_r(csr_mtvec_r)
  );

  //////////////////////////////////////////////////
  // Cycle helpers, all tasks start and end on a falling edge
  task automatic fall_edge();
    int   waited;
    logic seen_high;
    waited    = 0;
    seen_high = (clk === 1'b1);
    while (!(seen_high && clk === 1'b0) && waited < EDGE_TIMEOUT_NS) begin
      #1;
      waited++;
      if (clk === 1'b1) seen_high = 1'b1;
    end
    if (!(seen_high && clk === 1'b0)) begin
      $display("Timeout: clock made no falling edge within %0d ns", EDGE_TIMEOUT_NS);
      $display("Done: errors found");
      $finish;
    end
  endtask

  task automatic end_cycle();
    fall_edge();
    req = '0;                                // Requests and commits last one cycle
    cmt = '0;
  endtask

  task automatic post_write(input logic [CSR_IDX_W-1:0] idx, input logic [XLEN-1:0] data);
    req.ena      = 1'b1;
    req.wr_en    = 1'b1;
    req.rd_en    = 1'b0;
    req.idx      = idx;
    req.wdat.raw = data;
  endtask

  task automatic write_csr(input logic [CSR_IDX_W-1:0] idx, input logic [XLEN-1:0] data);
    post_write(idx, data);
    end_cycle();                             // Lands on the rising edge in between
  endtask

  task automatic read_csr(input logic [CSR_IDX_W-1:0] idx, output logic [XLEN-1:0] data);
    req.ena   = 1'b1;
    req.wr_en = 1'b0;
    req.rd_en = 1'b1;
    req.idx   = idx;
    #SETTLE_NS;
    data = read_csr_dat;                     // Combinational read path
    end_cycle();
  endtask

  task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string what);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("CHECK FAILED at %0t ns: %s, read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    for (int i = 0; i < 16; i++) fall_edge();
    rst_n = 1'b1;
    fall_edge();
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  task automatic plain_regs_rw();
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] rd;
    for (int i = 0; i < 4; i++) begin
      data = $random(seed);
      write_csr(ADDR_MSCRATCH, data);
      read_csr(ADDR_MSCRATCH, rd);
      check_eq(rd, data, "mscratch readback");
    end
    write_csr(ADDR_MIE, '1);
    read_csr(ADDR_MIE, rd);
    check_eq(rd, 32'h0000_0888, "mie keeps bits 11, 7 and 3");
    check_eq({29'b0, irq_en.meie, irq_en.mtie, irq_en.msie}, 32'h7, "irq_en enables");
    read_csr(ADDR_MISA, rd);
    check_eq(rd, MISA_VALUE, "misa");
    read_csr(ADDR_MVENDORID, rd);
    check_eq(rd, MVENDORID_VALUE, "mvendorid");
    read_csr(ADDR_MARCHID, rd);
    check_eq(rd, MARCHID_VALUE, "marchid");
    read_csr(ADDR_MIMPID, rd);
    check_eq(rd, MIMPID_VALUE, "mimpid");
    read_csr(ADDR_MHARTID, rd);
    check_eq(rd, 32'h0000_0001, "mhartid");
    read_csr(ADDR_MTVEC, rd);
    check_eq(rd, TB_MTVEC, "mtvec read");
    check_eq(csr_mtvec_r, TB_MTVEC, "csr_mtvec_r output");
    read_csr(12'h7C0, rd);                   // No register here
    check_eq(rd, '0, "unmapped index");
  endtask

  task automatic status_trap_mret();
    logic [XLEN-1:0] rd;
    write_csr(ADDR_MSTATUS, 32'h0000_0008);
    read_csr(ADDR_MSTATUS, rd);
    check_eq(rd & MSTATUS_LIVE, 32'h0000_0008, "mstatus MIE written");
    check_eq(XLEN'(irq_en.status_mie), 32'h1, "irq_en status_mie set");
    cmt.status_ena = 1'b1;
    end_cycle();
    read_csr(ADDR_MSTATUS, rd);
    check_eq(rd & MSTATUS_LIVE, 32'h0000_0080, "mstatus after trap");
    cmt.mret_ena = 1'b1;
    end_cycle();
    read_csr(ADDR_MSTATUS, rd);
    check_eq(rd & MSTATUS_LIVE, 32'h0000_0088, "mstatus after MRET");
    post_write(ADDR_MSTATUS, 32'h0000_0000);   // Same cycle as the trap
    cmt.status_ena = 1'b1;
    end_cycle();
    read_csr(ADDR_MSTATUS, rd);
    check_eq(rd & MSTATUS_LIVE, 32'h0000_0080, "trap beats mstatus write");
  endtask

  task automatic trap_reg_priority();
    logic [XLEN-1:0] rd;
    post_write(ADDR_MEPC, 32'h1111_2220);
    cmt.epc_ena = 1'b1;
    cmt.epc     = 32'h8000_1235;
    end_cycle();
    read_csr(ADDR_MEPC, rd);
    check_eq(rd, 32'h8000_1234, "mepc takes commit value");
    check_eq(csr_epc_r, 32'h8000_1234, "csr_epc_r output");
    write_csr(ADDR_MEPC, 32'h0000_0103);
    read_csr(ADDR_MEPC, rd);
    check_eq(rd, 32'h0000_0102, "mepc bit 0 dropped");
    post_write(ADDR_MCAUSE, 32'h0000_0000);
    cmt.cause_ena = 1'b1;
    cmt.cause     = '1;
    end_cycle();
    read_csr(ADDR_MCAUSE, rd);
    check_eq(rd, 32'h8000_000F, "mcause takes masked commit");
    write_csr(ADDR_MCAUSE, 32'h7FFF_FFF5);
    read_csr(ADDR_MCAUSE, rd);
    check_eq(rd, 32'h0000_0005, "mcause write mask");
  endtask

  task automatic mip_follows_irq();
    logic [2:0]      pat;
    logic [XLEN-1:0] exp;
    logic [XLEN-1:0] rd;
    for (int i = 0; i < 4; i++) begin
      pat    = 3'b100 >> i;                  // ext, sft, tmr, then none
      irq    = pat;
      exp    = '0;
      exp[11] = pat[2];
      exp[3]  = pat[1];
      exp[7]  = pat[0];
      end_cycle();                           // One edge to register the lines
      read_csr(ADDR_MIP, rd);
      check_eq(rd, exp, "mip follows irq lines");
    end
    irq = '0;
  endtask

  task automatic counter_behavior();
    logic [XLEN-1:0] rd;
    logic [XLEN-1:0] hi0;
    logic [XLEN-1:0] base;
    write_csr(ADDR_MCYCLE, 32'h0000_1000);
    read_csr(ADDR_MCYCLE, rd);
    check_eq(rd, 32'h0000_1000, "mcycle one cycle after write");
    end_cycle();
    read_csr(ADDR_MCYCLE, rd);
    check_eq(rd, 32'h0000_1002, "mcycle three cycles after write");

    // Carry into the high half
    read_csr(ADDR_MCYCLEH, hi0);
    write_csr(ADDR_MCYCLE, '1);
    read_csr(ADDR_MCYCLEH, rd);
    check_eq(rd, hi0, "mcycleh before wrap");
    read_csr(ADDR_MCYCLEH, rd);
    check_eq(rd, hi0 + 1, "mcycleh after wrap");

    write_csr(ADDR_COUNTERSTOP, 32'h0000_0001);  // Cycle count stop
    read_csr(ADDR_MCYCLE, base);
    end_cycle();
    end_cycle();
    read_csr(ADDR_MCYCLE, rd);
    check_eq(rd, base, "mcycle held by counterstop");
    write_csr(ADDR_COUNTERSTOP, '0);

    read_csr(ADDR_MINSTRET, base);
    for (int i = 0; i < 3; i++) begin
      cmt.instret_ena = 1'b1;
      end_cycle();
    end
    read_csr(ADDR_MINSTRET, rd);
    check_eq(rd, base + 3, "minstret counts retirements");
    write_csr(ADDR_COUNTERSTOP, 32'h0000_0004);  // Instret stop
    for (int i = 0; i < 2; i++) begin
      cmt.instret_ena = 1'b1;
      end_cycle();
    end
    read_csr(ADDR_MINSTRET, rd);
    check_eq(rd, base + 3, "minstret held by counterstop");
    write_csr(ADDR_COUNTERSTOP, '0);
  endtask

  task automatic custom_reg_masks();
    logic [XLEN-1:0] rd;
    core_ctl_t       exp_ctl;
    exp_ctl = '0;
    write_csr(ADDR_COUNTERSTOP, '1);
    read_csr(ADDR_COUNTERSTOP, rd);
    check_eq(rd, 32'h0000_0007, "counterstop keeps 3 bits");
    write_csr(ADDR_COUNTERSTOP, 32'h0000_0002);  // Timer stop alone
    exp_ctl.tm_stop = 1'b1;
    check_eq(XLEN'(core_ctl), XLEN'(exp_ctl), "tm_stop from counterstop bit 1");
    write_csr(ADDR_COUNTERSTOP, '0);
    exp_ctl.tm_stop = 1'b0;
    write_csr(ADDR_MCGSTOP, 32'h0000_0001);      // Core clock gate alone
    exp_ctl.core_cgstop = 1'b1;
    check_eq(XLEN'(core_ctl), XLEN'(exp_ctl), "core_cgstop from mcgstop bit 0");
    write_csr(ADDR_MCGSTOP, '1);
    read_csr(ADDR_MCGSTOP, rd);
    check_eq(rd, 32'h0000_0003, "mcgstop keeps 2 bits");
    exp_ctl.tcm_cgstop  = 1'b1;
    check_eq(XLEN'(core_ctl), XLEN'(exp_ctl), "clock gate stops");
    write_csr(ADDR_ITCMNOHOLD, '1);
    read_csr(ADDR_ITCMNOHOLD, rd);
    check_eq(rd, 32'h0000_0001, "itcmnohold keeps 1 bit");
    exp_ctl.itcm_nohold = 1'b1;
    check_eq(XLEN'(core_ctl), XLEN'(exp_ctl), "itcm_nohold flag");
    write_csr(ADDR_MDVNOB2B, 32'hFFFF_FFFE);       // Bit 0 clear
    read_csr(ADDR_MDVNOB2B, rd);
    check_eq(rd, 32'h0000_0000, "mdvnob2b ignores upper bits");
    write_csr(ADDR_MDVNOB2B, '1);
    exp_ctl.mdv_nob2b = 1'b1;
    check_eq(XLEN'(core_ctl), XLEN'(exp_ctl), "mdv_nob2b flag");
    write_csr(ADDR_MCGSTOP, '0);
    write_csr(ADDR_ITCMNOHOLD, '0);
    write_csr(ADDR_MDVNOB2B, '0);
    check_eq(XLEN'(core_ctl), '0, "core_ctl cleared");
  endtask

  //////////////////////////////////////////////////
  initial begin
    rst_n     = 1'b0;
    req       = '0;
    cmt       = '0;
    irq       = '0;
    check_cnt = 0;
    err_cnt   = 0;
    seed      = 32'h34e0;
    apply_reset();
    check_eq(XLEN'(irq_en), '0, "irq_en after reset");
    check_eq(XLEN'(core_ctl), '0, "core_ctl after reset");
    plain_regs_rw();
    status_trap_mret();
    trap_reg_priority();
    mip_follows_irq();
    counter_behavior();
    custom_reg_masks();
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             check_cnt, err_cnt, UUT.u_props.fail_cnt);
    if (err_cnt == 0 && UUT.u_props.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== testbench/csr_unit_properties.sv ====
// Concurrent checks on the CSR unit top level
// mepc alignment, MIE clear after a trap, core control quiet in reset
// Bound into every csr_unit_top instance
`timescale 1ns/1ps

module csr_unit_properties (
  input logic                     clk,
  input logic                     rst_n,
  input csr_pkg::cmt_t            cmt,
  input logic [csr_pkg::XLEN-1:0] mepc,
  input csr_pkg::irq_en_t         irq_en,
  input csr_pkg::core_ctl_t       core_ctl
);

  int fail_cnt = 0;  // Failed assertion count

  //////////////////////////////////////////////////
  // Exception PC is always halfword aligned
  a_mepc_even: assert property (@(posedge clk) disable iff (!rst_n) mepc[0] == 1'b0)
    else begin
      fail_cnt++;
      $error("mepc bit 0 is set");
    end

  // Trap entry turns interrupts off on the next edge
  a_trap_clears_mie: assert property (
    @(posedge clk) disable iff (!rst_n) cmt.status_ena |=> !irq_en.status_mie)
    else begin
      fail_cnt++;
      $error("status_mie still set in the cycle after a trap");
    end

  //////////////////////////////////////////////////
  // No core control line may be active during reset
  a_ctl_quiet_in_reset: assert property (@(negedge clk) !rst_n |-> core_ctl == '0)
    else begin
      fail_cnt++;
      $error("core_ctl not zero while rst_n is low");
    end

endmodule

bind csr_unit_top csr_unit_properties u_props (
  .clk(clk), .rst_n(rst_n), .cmt(cmt), .mepc(mepc), .irq_en(irq_en), .core_ctl(core_ctl)
);

// ==== testbench/tb_clock_gen.sv ====
// Free-running testbench clock
// Starts low, 40 ns period by default
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 40.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;                          // Known level at time zero
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// ==== hdl/csr_unit_top.sv ====
// Machine-mode CSR unit top level
// Index decode, status/interrupt, trap, counter and custom groups
// AND-OR read path and the trap vector output
`timescale 1ns/1ps

module csr_unit_top #(
  parameter logic [csr_pkg::HART_ID_W-1:0] HART_ID    = '0,
  parameter logic [csr_pkg::XLEN-1:0]      MTVEC_BASE = csr_pkg::MTVEC_BASE_DEFAULT
) (
  input  logic                         clk,
  input  logic                         clk_aon,   // Always-on clock for mcycle
  input  logic                         rst_n,
  input  csr_pkg::csr_req_t            req,
  input  csr_pkg::cmt_t                cmt,
  input  csr_pkg::irq_in_t             irq,
  output logic [csr_pkg::XLEN-1:0]     read_csr_dat,
  output csr_pkg::irq_en_t             irq_en,
  output csr_pkg::core_ctl_t           core_ctl,
  output logic [csr_pkg::PC_SIZE-1:0]  csr_epc_r,
  output logic [csr_pkg::XLEN-1:0]     csr_mtvec_r
);
  import csr_pkg::*;

  csr_sel_t        wr_sel;
  csr_sel_t        rd_sel;
  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mie;
  logic [XLEN-1:0] mip;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mscratch;
  logic [XLEN-1:0] mcycle;
  logic [XLEN-1:0] mcycleh;
  logic [XLEN-1:0] minstret;
  logic [XLEN-1:0] minstreth;
  logic [XLEN-1:0] counterstop;
  logic [XLEN-1:0] mcgstop;
  logic [XLEN-1:0] itcmnohold;
  logic [XLEN-1:0] mdvnob2b;
  logic            cy_stop;
  logic            ir_stop;

  assign csr_epc_r   = mepc[PC_SIZE-1:0];
  assign csr_mtvec_r = MTVEC_BASE;       // Read-only vector base

  csr_addr_decode u_decode (.req(req), .wr_sel(wr_sel), .rd_sel(rd_sel));

  csr_status_irq u_status_irq (
    .clk(clk), .rst_n(rst_n), .wr_sel(wr_sel), .wdata(req.wdat), .cmt(cmt), .irq(irq),
    .mstatus(mstatus), .mie(mie), .mip(mip), .irq_en(irq_en)
  );

  csr_trap_regs u_trap_regs (
    .clk(clk), .rst_n(rst_n), .wr_sel(wr_sel), .wdata(req.wdat.raw), .cmt(cmt),
    .mepc(mepc), .mcause(mcause), .mscratch(mscratch)
  );

  csr_counters u_counters (
    .clk(clk), .clk_aon(clk_aon), .rst_n(rst_n), .wr_sel(wr_sel), .wdata(req.wdat.raw),
    .instret_ena(cmt.instret_ena), .cy_stop(cy_stop), .ir_stop(ir_stop),
    .mcycle(mcycle), .mcycleh(mcycleh), .minstret(minstret), .minstreth(minstreth)
  );

  csr_custom_regs u_custom_regs (
    .clk(clk), .rst_n(rst_n), .wr_sel(wr_sel), .wdata(req.wdat.raw),
    .counterstop(counterstop), .mcgstop(mcgstop), .itcmnohold(itcmnohold),
    .mdvnob2b(mdvnob2b), .cy_stop(cy_stop), .ir_stop(ir_stop), .core_ctl(core_ctl)
  );

  csr_read_mux #(.HART_ID(HART_ID), .MTVEC_BASE(MTVEC_BASE)) u_read_mux (
    .rd_sel(rd_sel), .mstatus(mstatus), .mie(mie), .mip(mip), .mepc(mepc),
    .mcause(mcause), .mscratch(mscratch), .mcycle(mcycle), .mcycleh(mcycleh),
    .minstret(minstret), .minstreth(minstreth), .counterstop(counterstop),
    .mcgstop(mcgstop), .itcmnohold(itcmnohold), .mdvnob2b(mdvnob2b),
    .read_csr_dat(read_csr_dat)
  );

endmodule

// ==== hdl/csr_read_mux.sv ====
// CSR read path
// AND-OR of every register with its read strobe
// Constant information registers and mtvec
`timescale 1ns/1ps

module csr_read_mux #(
  parameter logic [csr_pkg::HART_ID_W-1:0] HART_ID    = '0,
  parameter logic [csr_pkg::XLEN-1:0]      MTVEC_BASE = csr_pkg::MTVEC_BASE_DEFAULT
) (
  input  csr_pkg::csr_sel_t        rd_sel,
  input  logic [csr_pkg::XLEN-1:0] mstatus,
  input  logic [csr_pkg::XLEN-1:0] mie,
  input  logic [csr_pkg::XLEN-1:0] mip,
  input  logic [csr_pkg::XLEN-1:0] mepc,
  input  logic [csr_pkg::XLEN-1:0] mcause,
  input  logic [csr_pkg::XLEN-1:0] mscratch,
  input  logic [csr_pkg::XLEN-1:0] mcycle,
  input  logic [csr_pkg::XLEN-1:0] mcycleh,
  input  logic [csr_pkg::XLEN-1:0] minstret,
  input  logic [csr_pkg::XLEN-1:0] minstreth,
  input  logic [csr_pkg::XLEN-1:0] counterstop,
  input  logic [csr_pkg::XLEN-1:0] mcgstop,
  input  logic [csr_pkg::XLEN-1:0] itcmnohold,
  input  logic [csr_pkg::XLEN-1:0] mdvnob2b,
  output logic [csr_pkg::XLEN-1:0] read_csr_dat
);
  import csr_pkg::*;

  logic [XLEN-1:0] mhartid_w;

  assign mhartid_w = XLEN'(HART_ID);  // Zero-extended hart id

  // Unmapped index selects nothing and reads zero
  assign read_csr_dat = ({XLEN{rd_sel.mstatus}}     & mstatus)
                      | ({XLEN{rd_sel.misa}}        & MISA_VALUE)
                      | ({XLEN{rd_sel.mie}}         & mie)
                      | ({XLEN{rd_sel.mtvec}}       & MTVEC_BASE)
                      | ({XLEN{rd_sel.mscratch}}    & mscratch)
                      | ({XLEN{rd_sel.mepc}}        & mepc)
                      | ({XLEN{rd_sel.mcause}}      & mcause)
                      | ({XLEN{rd_sel.mip}}         & mip)
                      | ({XLEN{rd_sel.mcycle}}      & mcycle)
                      | ({XLEN{rd_sel.mcycleh}}     & mcycleh)
                      | ({XLEN{rd_sel.minstret}}    & minstret)
                      | ({XLEN{rd_sel.minstreth}}   & minstreth)
                      | ({XLEN{rd_sel.counterstop}} & counterstop)  // Custom
                      | ({XLEN{rd_sel.mcgstop}}     & mcgstop)      // Custom
                      | ({XLEN{rd_sel.itcmnohold}}  & itcmnohold)   // Custom
                      | ({XLEN{rd_sel.mdvnob2b}}    & mdvnob2b)     // Custom
                      | ({XLEN{rd_sel.mvendorid}}   & MVENDORID_VALUE)
                      | ({XLEN{rd_sel.marchid}}     & MARCHID_VALUE)
                      | ({XLEN{rd_sel.mimpid}}      & MIMPID_VALUE)
                      | ({XLEN{rd_sel.mhartid}}     & mhartid_w);

endmodule

// ==== hdl/csr_custom_regs.sv ====
// Custom control registers: counterstop, mcgstop, itcmnohold, mdvnob2b
// Counter stop lines and core control outputs
`timescale 1ns/1ps

module csr_custom_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  csr_pkg::csr_sel_t        wr_sel,
  input  logic [csr_pkg::XLEN-1:0] wdata,
  output logic [csr_pkg::XLEN-1:0] counterstop,
  output logic [csr_pkg::XLEN-1:0] mcgstop,
  output logic [csr_pkg::XLEN-1:0] itcmnohold,
  output logic [csr_pkg::XLEN-1:0] mdvnob2b,
  output logic                     cy_stop,
  output logic                     ir_stop,
  output csr_pkg::core_ctl_t       core_ctl
);
  import csr_pkg::*;

  logic [2:0] counterstop_r;  // 0 cycle, 1 time, 2 instret
  logic [1:0] mcgstop_r;      // 0 core, 1 TCM clock gating
  logic       itcmnohold_r;
  logic       mdvnob2b_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      counterstop_r <= '0;
      mcgstop_r     <= '0;
      itcmnohold_r  <= 1'b0;
      mdvnob2b_r    <= 1'b0;
    end else begin
      if (wr_sel.counterstop) counterstop_r <= wdata[2:0];
      if (wr_sel.mcgstop)     mcgstop_r     <= wdata[1:0];
      if (wr_sel.itcmnohold)  itcmnohold_r  <= wdata[0];
      if (wr_sel.mdvnob2b)    mdvnob2b_r    <= wdata[0];
    end
  end

  // Upper bits read back as zero
  assign counterstop = XLEN'(counterstop_r);
  assign mcgstop     = XLEN'(mcgstop_r);
  assign itcmnohold  = XLEN'(itcmnohold_r);
  assign mdvnob2b    = XLEN'(mdvnob2b_r);

  assign cy_stop  = counterstop_r[0];
  assign ir_stop  = counterstop_r[2];
  assign core_ctl = '{tm_stop:     counterstop_r[1],
                      core_cgstop: mcgstop_r[0],
                      tcm_cgstop:  mcgstop_r[1],
                      itcm_nohold: itcmnohold_r,   // ITCM output not held
                      mdv_nob2b:   mdvnob2b_r};    // No back-to-back mul/div

endmodule

// ==== hdl/csr_counters.sv ====
// mcycle/mcycleh and minstret/minstreth counters
// Write load, carry into the high half, stop gating
// mcycle pair on the always-on clock, minstret pair on the core clock
`timescale 1ns/1ps

module csr_counters (
  input  logic                     clk,
  input  logic                     clk_aon,
  input  logic                     rst_n,
  input  csr_pkg::csr_sel_t        wr_sel,
  input  logic [csr_pkg::XLEN-1:0] wdata,
  input  logic                     instret_ena,  // Instruction retired
  input  logic                     cy_stop,
  input  logic                     ir_stop,
  output logic [csr_pkg::XLEN-1:0] mcycle,
  output logic [csr_pkg::XLEN-1:0] mcycleh,
  output logic [csr_pkg::XLEN-1:0] minstret,
  output logic [csr_pkg::XLEN-1:0] minstreth
);
  import csr_pkg::*;

  // Index 0 is the cycle counter, index 1 the instret counter
  logic [1:0] cnt_clk;
  logic [1:0] lo_wr;
  logic [1:0] hi_wr;
  logic [1:0] step;    // Low half advances

  assign cnt_clk = {clk, clk_aon};
  assign lo_wr   = {wr_sel.minstret, wr_sel.mcycle};
  assign hi_wr   = {wr_sel.minstreth, wr_sel.mcycleh};
  assign step    = {instret_ena & ~ir_stop, ~cy_stop};

  for (genvar g = 0; g < 2; g++) begin : g_cnt
    logic            carry;  // Low half wraps this cycle
    logic [XLEN-1:0] lo_r;
    logic [XLEN-1:0] hi_r;

    assign carry = step[g] & ~lo_wr[g] & (&lo_r);

    always_ff @(posedge cnt_clk[g] or negedge rst_n) begin
      if (!rst_n) begin
        lo_r <= '0;
        hi_r <= '0;
      end else begin
        if (lo_wr[g])
          lo_r <= wdata;             // Write beats counting
        else if (step[g])
          lo_r <= lo_r + 1'b1;
        if (hi_wr[g])
          hi_r <= wdata;
        else if (carry)
          hi_r <= hi_r + 1'b1;
      end
    end
  end

  assign mcycle    = g_cnt[0].lo_r;
  assign mcycleh   = g_cnt[0].hi_r;
  assign minstret  = g_cnt[1].lo_r;
  assign minstreth = g_cnt[1].hi_r;

endmodule

// ==== hdl/csr_trap_regs.sv ====
// Trap registers: mepc, mcause and mscratch
// Commit stage updates win over CSR writes
`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  csr_pkg::csr_sel_t        wr_sel,
  input  logic [csr_pkg::XLEN-1:0] wdata,
  input  csr_pkg::cmt_t            cmt,
  output logic [csr_pkg::XLEN-1:0] mepc,
  output logic [csr_pkg::XLEN-1:0] mcause,
  output logic [csr_pkg::XLEN-1:0] mscratch
);
  import csr_pkg::*;

  logic [PC_SIZE-1:1] epc_r;         // Bit 0 not stored, a PC is never odd
  logic               cause_int_r;   // Interrupt flag, bit 31
  logic [3:0]         cause_code_r;  // Exception code
  logic [XLEN-1:0]    mscratch_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      epc_r        <= '0;
      cause_int_r  <= 1'b0;
      cause_code_r <= '0;
      mscratch_r   <= '0;
    end else begin
      if (cmt.epc_ena)
        epc_r <= cmt.epc[PC_SIZE-1:1];
      else if (wr_sel.mepc)
        epc_r <= wdata[PC_SIZE-1:1];
      if (cmt.cause_ena) begin
        cause_int_r  <= cmt.cause[XLEN-1];
        cause_code_r <= cmt.cause[3:0];
      end else if (wr_sel.mcause) begin
        cause_int_r  <= wdata[XLEN-1];
        cause_code_r <= wdata[3:0];
      end
      if (wr_sel.mscratch)
        mscratch_r <= wdata;
    end
  end

  assign mepc     = XLEN'({epc_r, 1'b0});
  assign mcause   = {cause_int_r, {(XLEN-5){1'b0}}, cause_code_r};
  assign mscratch = mscratch_r;

endmodule

// ==== hdl/csr_status_irq.sv ====
// mstatus MIE/MPIE with trap, MRET and write priority
// mie enable bits and the registered mip pending bits
// Interrupt enable outputs to the core
`timescale 1ns/1ps

module csr_status_irq (
  input  logic                     clk,
  input  logic                     rst_n,
  input  csr_pkg::csr_sel_t        wr_sel,
  input  csr_pkg::csr_word_u       wdata,
  input  csr_pkg::cmt_t            cmt,
  input  csr_pkg::irq_in_t         irq,
  output logic [csr_pkg::XLEN-1:0] mstatus,
  output logic [csr_pkg::XLEN-1:0] mie,
  output logic [csr_pkg::XLEN-1:0] mip,
  output csr_pkg::irq_en_t         irq_en
);
  import csr_pkg::*;

  logic      status_mie_r;
  logic      status_mpie_r;
  logic      meie_r;
  logic      mtie_r;
  logic      msie_r;
  logic      meip_r;
  logic      mtip_r;
  logic      msip_r;
  mstatus_t  stat_w;
  irq_bits_t ie_w;
  irq_bits_t ip_w;

  //////////////////////////////////////////////////
  // mstatus: trap, then MRET, then CSR write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_mie_r  <= 1'b0;
      status_mpie_r <= 1'b0;
    end else if (cmt.status_ena) begin
      status_mpie_r <= status_mie_r;        // Save current MIE
      status_mie_r  <= 1'b0;                // Interrupts off in handler
    end else if (cmt.mret_ena) begin
      status_mie_r  <= status_mpie_r;       // Restore
      status_mpie_r <= 1'b1;
    end else if (wr_sel.mstatus) begin
      status_mie_r  <= wdata.mstatus.mie;
      status_mpie_r <= wdata.mstatus.mpie;
    end
  end

  //////////////////////////////////////////////////
  // mie keeps three enables, mip samples the lines
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meie_r <= 1'b0;
      mtie_r <= 1'b0;
      msie_r <= 1'b0;
      meip_r <= 1'b0;
      mtip_r <= 1'b0;
      msip_r <= 1'b0;
    end else begin
      if (wr_sel.mie) begin
        meie_r <= wdata.irq.ext;
        mtie_r <= wdata.irq.tmr;
        msie_r <= wdata.irq.sft;
      end
      meip_r <= irq.ext;                    // mip is read-only
      mtip_r <= irq.tmr;
      msip_r <= irq.sft;
    end
  end

  always_comb begin
    stat_w      = '0;
    stat_w.mpp  = MSTATUS_MPP_M;
    stat_w.mpie = status_mpie_r;
    stat_w.mie  = status_mie_r;
    ie_w        = '0;
    ie_w.ext    = meie_r;
    ie_w.tmr    = mtie_r;
    ie_w.sft    = msie_r;
    ip_w        = '0;
    ip_w.ext    = meip_r;
    ip_w.tmr    = mtip_r;
    ip_w.sft    = msip_r;
  end

  assign mstatus = stat_w;
  assign mie     = ie_w;
  assign mip     = ip_w;
  assign irq_en  = '{status_mie: status_mie_r, meie: meie_r, mtie: mtie_r, msie: msie_r};

endmodule

// ==== hdl/csr_addr_decode.sv ====
// CSR index decode
// One-hot index match, qualified into write and read strobes
`timescale 1ns/1ps

module csr_addr_decode (
  input  csr_pkg::csr_req_t req,
  output csr_pkg::csr_sel_t wr_sel,
  output csr_pkg::csr_sel_t rd_sel
);
  import csr_pkg::*;

  csr_sel_t hit;   // Raw index match
  logic     wr_q;  // Access is a write
  logic     rd_q;  // Access is a read

  always_comb begin
    hit             = '0;
    hit.mstatus     = (req.idx == ADDR_MSTATUS);
    hit.misa        = (req.idx == ADDR_MISA);
    hit.mie         = (req.idx == ADDR_MIE);
    hit.mtvec       = (req.idx == ADDR_MTVEC);
    hit.mscratch    = (req.idx == ADDR_MSCRATCH);
    hit.mepc        = (req.idx == ADDR_MEPC);
    hit.mcause      = (req.idx == ADDR_MCAUSE);
    hit.mip         = (req.idx == ADDR_MIP);
    hit.mcycle      = (req.idx == ADDR_MCYCLE);
    hit.mcycleh     = (req.idx == ADDR_MCYCLEH);
    hit.minstret    = (req.idx == ADDR_MINSTRET);
    hit.minstreth   = (req.idx == ADDR_MINSTRETH);
    hit.counterstop = (req.idx == ADDR_COUNTERSTOP);
    hit.mcgstop     = (req.idx == ADDR_MCGSTOP);
    hit.itcmnohold  = (req.idx == ADDR_ITCMNOHOLD);
    hit.mdvnob2b    = (req.idx == ADDR_MDVNOB2B);
    hit.mvendorid   = (req.idx == ADDR_MVENDORID);
    hit.marchid     = (req.idx == ADDR_MARCHID);
    hit.mimpid      = (req.idx == ADDR_MIMPID);
    hit.mhartid     = (req.idx == ADDR_MHARTID);
  end

  // Strobes only toggle on a real access, saves read mux power
  assign wr_q = req.ena & req.wr_en;
  assign rd_q = req.ena & req.rd_en;

  assign wr_sel = hit & {$bits(csr_sel_t){wr_q}};
  assign rd_sel = hit & {$bits(csr_sel_t){rd_q}};

endmodule

// ==== hdl/csr_pkg.sv ====
// Shared definitions of the machine-mode CSR unit
// Widths, CSR index map and fixed identification words
// Request, commit, interrupt and core control structs
// mstatus and interrupt-bit word layouts, write-data union
package csr_pkg;

  parameter int XLEN      = 32;
  parameter int PC_SIZE   = 32;
  parameter int HART_ID_W = 1;
  parameter int CSR_IDX_W = 12;

  //////////////////////////////////////////////////
  // CSR index map
  parameter logic [CSR_IDX_W-1:0] ADDR_MSTATUS     = 12'h300;
  parameter logic [CSR_IDX_W-1:0] ADDR_MISA        = 12'h301;
  parameter logic [CSR_IDX_W-1:0] ADDR_MIE         = 12'h304;
  parameter logic [CSR_IDX_W-1:0] ADDR_MTVEC       = 12'h305;
  parameter logic [CSR_IDX_W-1:0] ADDR_MSCRATCH    = 12'h340;
  parameter logic [CSR_IDX_W-1:0] ADDR_MEPC        = 12'h341;
  parameter logic [CSR_IDX_W-1:0] ADDR_MCAUSE      = 12'h342;
  parameter logic [CSR_IDX_W-1:0] ADDR_MIP         = 12'h344;
  parameter logic [CSR_IDX_W-1:0] ADDR_MCYCLE      = 12'hB00;
  parameter logic [CSR_IDX_W-1:0] ADDR_MINSTRET    = 12'hB02;
  parameter logic [CSR_IDX_W-1:0] ADDR_MCYCLEH     = 12'hB80;
  parameter logic [CSR_IDX_W-1:0] ADDR_MINSTRETH   = 12'hB82;
  parameter logic [CSR_IDX_W-1:0] ADDR_MDVNOB2B    = 12'hBF0; // Custom, outside the ISA map
  parameter logic [CSR_IDX_W-1:0] ADDR_ITCMNOHOLD  = 12'hBFD;
  parameter logic [CSR_IDX_W-1:0] ADDR_MCGSTOP     = 12'hBFE;
  parameter logic [CSR_IDX_W-1:0] ADDR_COUNTERSTOP = 12'hBFF;
  parameter logic [CSR_IDX_W-1:0] ADDR_MVENDORID   = 12'hF11;
  parameter logic [CSR_IDX_W-1:0] ADDR_MARCHID     = 12'hF12;
  parameter logic [CSR_IDX_W-1:0] ADDR_MIMPID      = 12'hF13;
  parameter logic [CSR_IDX_W-1:0] ADDR_MHARTID     = 12'hF14;

  //////////////////////////////////////////////////
  // Fixed values
  parameter logic [XLEN-1:0] MISA_VALUE         = 32'h4000_1104; // RV32, M, I, C
  parameter logic [XLEN-1:0] MVENDORID_VALUE    = 32'h0000_0536;
  parameter logic [XLEN-1:0] MARCHID_VALUE      = 32'h0000_E203;
  parameter logic [XLEN-1:0] MIMPID_VALUE       = 32'h0000_0001;
  parameter logic [XLEN-1:0] MTVEC_BASE_DEFAULT = 32'h8000_0000;
  parameter logic [1:0]      MSTATUS_MPP_M      = 2'b11;         // Always machine mode

  typedef struct packed {
    logic [18:0] rsvd_31_13;
    logic [1:0]  mpp;
    logic [2:0]  rsvd_10_8;
    logic        mpie;       // Bit 7
    logic [2:0]  rsvd_6_4;
    logic        mie;        // Bit 3
    logic [2:0]  rsvd_2_0;
  } mstatus_t;

  // Shared by mie and mip
  typedef struct packed {
    logic [19:0] rsvd_31_12;
    logic        ext;        // Bit 11
    logic [2:0]  rsvd_10_8;
    logic        tmr;        // Bit 7
    logic [2:0]  rsvd_6_4;
    logic        sft;        // Bit 3
    logic [2:0]  rsvd_2_0;
  } irq_bits_t;

  typedef union packed {
    logic [XLEN-1:0] raw;
    mstatus_t        mstatus;
    irq_bits_t       irq;
  } csr_word_u;

  typedef struct packed {
    logic                 ena;
    logic                 wr_en;
    logic                 rd_en;
    logic [CSR_IDX_W-1:0] idx;
    csr_word_u            wdat;
  } csr_req_t;

  typedef struct packed {
    logic               status_ena;  // Trap taken
    logic               mret_ena;
    logic               epc_ena;
    logic [PC_SIZE-1:0] epc;
    logic               cause_ena;
    logic [XLEN-1:0]    cause;
    logic               instret_ena;
  } cmt_t;

  typedef struct packed {
    logic ext;
    logic sft;
    logic tmr;
  } irq_in_t;

  // One select per register
  typedef struct packed {
    logic mstatus;
    logic misa;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mip;
    logic mcycle;
    logic mcycleh;
    logic minstret;
    logic minstreth;
    logic counterstop;
    logic mcgstop;
    logic itcmnohold;
    logic mdvnob2b;
    logic mvendorid;
    logic marchid;
    logic mimpid;
    logic mhartid;
  } csr_sel_t;

  typedef struct packed {
    logic status_mie;
    logic meie;
    logic mtie;
    logic msie;
  } irq_en_t;

  typedef struct packed {
    logic tm_stop;
    logic core_cgstop;
    logic tcm_cgstop;
    logic itcm_nohold;
    logic mdv_nob2b;
  } core_ctl_t;

endpackage
